// ==== verilog/buzzer_defines.svh ====
`ifndef BUZZER_DEFINES_SVH
`define BUZZER_DEFINES_SVH

// Note codes 1 to 108 span nine octaves and 0 is a rest
`define NOTE_W          7
`define NOTE_MAX        108

`define FREQ_W          14
`define DUR_W           13

// Half a second in microsecond-Hz units
`define HALF_WAVE_UNITS 500000
`define ACC_W           19

`define SONG_LEN        24
`define STEP_W          5

`endif

// ==== verilog/music_pkg.sv ====
`default_nettype none

package music_pkg;

	`include "buzzer_defines.svh"

	typedef logic [`NOTE_W-1:0] note_code_t;
	typedef logic [`FREQ_W-1:0] freq_t;
	typedef logic [`DUR_W-1:0] dur_t;

	typedef enum logic [3:0] {
		C, Db, D, Eb, E, F, Gb, G, Ab, A, Bb, B
	} semitone_e;

	localparam note_code_t note_rest = '0;

	// Octave 1 starts at code 1
	function automatic note_code_t mk_note(semitone_e s, int unsigned octave);
		int unsigned code;
		code = (octave - 1) * 12 + int'(s) + 1;
		return note_code_t'(code);
	endfunction

endpackage

`default_nettype wire

// ==== verilog/player_pkg.sv ====
`default_nettype none

package player_pkg;

	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		HOLD,
		MANUAL
	} seq_state_e;

endpackage

`default_nettype wire

// ==== verilog/time_base.sv ====
`timescale 1ns/1ps
`default_nettype none

module time_base #(
	parameter int cycles_per_usec = 50,
	parameter int usec_per_msec = 1000
) (
	input  logic clk,
	input  logic reset_p,
	output logic usec_tick,
	output logic msec_tick
);

	localparam int cyc_w = (cycles_per_usec > 1) ? $clog2(cycles_per_usec) : 1;
	localparam int usec_w = (usec_per_msec > 1) ? $clog2(usec_per_msec) : 1;

	logic [cyc_w-1:0] cyc_cnt;
	logic [usec_w-1:0] usec_cnt;

	// Tick is registered so the first one lands at cycle cycles_per_usec
	always_ff @(posedge clk or posedge reset_p) begin
		if (reset_p) begin
			cyc_cnt <= '0;
			usec_tick <= 1'b0;
		end else if (cyc_cnt == cyc_w'(cycles_per_usec - 1)) begin
			cyc_cnt <= '0;
			usec_tick <= 1'b1;
		end else begin
			cyc_cnt <= cyc_cnt + 1'b1;
			usec_tick <= 1'b0;
		end
	end

	always_ff @(posedge clk or posedge reset_p) begin
		if (reset_p) begin
			usec_cnt <= '0;
		end else if (msec_tick) begin
			usec_cnt <= '0;
		end else if (usec_tick) begin
			usec_cnt <= usec_cnt + 1'b1;
		end
	end

	assign msec_tick = usec_tick && (usec_cnt == usec_w'(usec_per_msec - 1));

endmodule

`default_nettype wire

// ==== verilog/pitch_table.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "buzzer_defines.svh"

module pitch_table import music_pkg::*; (
	input  note_code_t note,
	output freq_t      freq
);

	note_code_t idx;
	logic [3:0] octave;
	semitone_e semi;
	freq_t top;

	always_comb begin
		idx = note - 1'b1;
		octave = 4'(idx / 12) + 4'd1;
		semi = semitone_e'(4'(idx % 12));
	end

	// Octave 9 values that the lower octaves derive from by halving
	always_comb begin
		case (semi)
			C:       top = 14'd8372;
			Db:      top = 14'd8870;
			D:       top = 14'd9397;
			Eb:      top = 14'd9956;
			E:       top = 14'd10548;
			F:       top = 14'd11175;
			Gb:      top = 14'd11840;
			G:       top = 14'd12544;
			Ab:      top = 14'd13290;
			A:       top = 14'd14080;
			Bb:      top = 14'd14917;
			B:       top = 14'd15804;
			default: top = '0;
		endcase
	end

	always_comb begin
		if (note == note_rest || note > `NOTE_W'(`NOTE_MAX)) begin
			freq = '0;
		end else begin
			freq = top >> (4'd9 - octave);
		end
	end

endmodule

`default_nettype wire

// ==== verilog/tone_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "buzzer_defines.svh"

module tone_gen import music_pkg::*; (
	input  logic       clk,
	input  logic       reset_p,
	input  logic       usec_tick,
	input  note_code_t note,
	input  freq_t      freq,
	output logic       buz_clk
);

	localparam logic [`ACC_W-1:0] half_wave = `ACC_W'(`HALF_WAVE_UNITS);

	note_code_t prev_note;
	logic [`ACC_W-1:0] acc;
	logic [`ACC_W-1:0] sum;
	logic note_chg;

	assign note_chg = (note != prev_note);

	// Both operands stay below the threshold, so the sum fits ACC_W
	assign sum = acc + `ACC_W'(freq);

	always_ff @(posedge clk or posedge reset_p) begin
		if (reset_p) begin
			prev_note <= note_rest;
			acc <= '0;
			buz_clk <= 1'b0;
		end else begin
			prev_note <= note;
			if (note_chg) begin
				// New note restarts the phase
				acc <= '0;
				buz_clk <= 1'b0;
			end else if (usec_tick) begin
				if (sum >= half_wave) begin
					acc <= sum - half_wave;
					buz_clk <= ~buz_clk;
				end else begin
					acc <= sum;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/song_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "buzzer_defines.svh"

module song_rom import music_pkg::*; (
	input  logic [`STEP_W-1:0] step,
	output note_code_t         rom_note,
	output dur_t               rom_dur
);

	// Note lengths in ms at the halved tempo
	localparam dur_t len_s = dur_t'(62);
	localparam dur_t len_e = dur_t'(125);
	localparam dur_t len_d = dur_t'(187);
	localparam dur_t len_skip = dur_t'(0);

	// Each note is followed by a rest of the same length
	always_comb begin
		case (step)
			5'd0:    {rom_note, rom_dur} = {mk_note(D, 4), len_s};
			5'd1:    {rom_note, rom_dur} = {note_rest, len_s};
			5'd2:    {rom_note, rom_dur} = {mk_note(D, 4), len_s};
			5'd3:    {rom_note, rom_dur} = {note_rest, len_s};
			5'd4:    {rom_note, rom_dur} = {mk_note(D, 5), len_e};
			5'd5:    {rom_note, rom_dur} = {note_rest, len_e};
			5'd6:    {rom_note, rom_dur} = {mk_note(A, 4), len_d};
			5'd7:    {rom_note, rom_dur} = {note_rest, len_d};
			5'd8:    {rom_note, rom_dur} = {mk_note(Ab, 4), len_e};
			5'd9:    {rom_note, rom_dur} = {note_rest, len_e};
			5'd10:   {rom_note, rom_dur} = {mk_note(G, 4), len_e};
			5'd11:   {rom_note, rom_dur} = {note_rest, len_e};
			5'd12:   {rom_note, rom_dur} = {mk_note(F, 4), len_e};
			5'd13:   {rom_note, rom_dur} = {note_rest, len_e};
			5'd14:   {rom_note, rom_dur} = {mk_note(D, 4), len_s};
			5'd15:   {rom_note, rom_dur} = {note_rest, len_s};
			5'd16:   {rom_note, rom_dur} = {mk_note(F, 4), len_s};
			5'd17:   {rom_note, rom_dur} = {note_rest, len_s};
			5'd18:   {rom_note, rom_dur} = {mk_note(G, 4), len_s};
			5'd19:   {rom_note, rom_dur} = {note_rest, len_s};
			5'd20:   {rom_note, rom_dur} = {mk_note(C, 4), len_s};
			5'd21:   {rom_note, rom_dur} = {note_rest, len_s};
			// Skipped entry that never sounds
			5'd22:   {rom_note, rom_dur} = {mk_note(B, 3), len_skip};
			5'd23:   {rom_note, rom_dur} = {mk_note(C, 4), len_s};
			default: {rom_note, rom_dur} = {note_rest, len_skip};
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/melody_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "buzzer_defines.svh"

module melody_sequencer import music_pkg::*, player_pkg::*; (
	input  logic               clk,
	input  logic               reset_p,
	input  logic               msec_tick,
	input  logic               play_start,
	input  logic               play_stop,
	input  logic               manual_en,
	input  note_code_t         manual_note,
	input  note_code_t         rom_note,
	input  dur_t               rom_dur,
	output logic [`STEP_W-1:0] step,
	output note_code_t         note,
	output logic               playing
);

	seq_state_e state;
	dur_t remain;
	logic last_step;

	assign last_step = (step == `STEP_W'(`SONG_LEN - 1));

	always_ff @(posedge clk or posedge reset_p) begin
		if (reset_p) begin
			state <= IDLE;
			step <= '0;
			remain <= '0;
			note <= note_rest;
			playing <= 1'b0;
		end else if (manual_en) begin
			// Manual override wins over everything else
			state <= MANUAL;
			note <= manual_note;
			playing <= 1'b0;
		end else if (play_stop) begin
			state <= IDLE;
			note <= note_rest;
			playing <= 1'b0;
		end else if (play_start) begin
			state <= LOAD;
			step <= '0;
			playing <= 1'b1;
		end else begin
			case (state)
				LOAD: begin
					if (rom_dur == '0) begin
						// Zero length moves on and leaves note as it is
						if (last_step) begin
							state <= IDLE;
							note <= note_rest;
							playing <= 1'b0;
						end else begin
							step <= step + 1'b1;
						end
					end else begin
						note <= rom_note;
						remain <= rom_dur;
						state <= HOLD;
					end
				end
				HOLD: begin
					if (msec_tick) begin
						if (remain == dur_t'(1)) begin
							if (last_step) begin
								state <= IDLE;
								note <= note_rest;
								playing <= 1'b0;
							end else begin
								step <= step + 1'b1;
								state <= LOAD;
							end
						end else begin
							remain <= remain - 1'b1;
						end
					end
				end
				MANUAL: begin
					state <= IDLE;
					note <= note_rest;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/buzzer_player_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "buzzer_defines.svh"

module buzzer_player_top import music_pkg::*; #(
	parameter int cycles_per_usec = 50,
	parameter int usec_per_msec = 1000
) (
	input  logic       clk,
	input  logic       reset_p,
	input  logic       play_start,
	input  logic       play_stop,
	input  logic       manual_en,
	input  note_code_t manual_note,
	output logic       buz_clk,
	output logic       playing,
	output note_code_t note
);

	logic usec_tick;
	logic msec_tick;
	logic [`STEP_W-1:0] step;
	note_code_t rom_note;
	dur_t rom_dur;
	freq_t freq;

	time_base #(
		.cycles_per_usec(cycles_per_usec),
		.usec_per_msec(usec_per_msec)
	) time_base0 (
		.clk(clk),
		.reset_p(reset_p),
		.usec_tick(usec_tick),
		.msec_tick(msec_tick)
	);

	melody_sequencer seq0 (
		.clk(clk),
		.reset_p(reset_p),
		.msec_tick(msec_tick),
		.play_start(play_start),
		.play_stop(play_stop),
		.manual_en(manual_en),
		.manual_note(manual_note),
		.rom_note(rom_note),
		.rom_dur(rom_dur),
		.step(step),
		.note(note),
		.playing(playing)
	);

	song_rom rom0 (
		.step(step),
		.rom_note(rom_note),
		.rom_dur(rom_dur)
	);

	pitch_table pitch0 (
		.note(note),
		.freq(freq)
	);

	tone_gen tone0 (
		.clk(clk),
		.reset_p(reset_p),
		.usec_tick(usec_tick),
		.note(note),
		.freq(freq),
		.buz_clk(buz_clk)
	);

endmodule

`default_nettype wire

// ==== sim/tb_buzzer_player.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "buzzer_defines.svh"

module tb_buzzer_player;

	typedef logic [`NOTE_W-1:0] code_t;

	localparam int cyc_per_us = 2;
	localparam int cyc_per_ms = 20;
	localparam int cycle_ns = 20;

	logic clk;
	logic reset_p;
	logic play_start;
	logic play_stop;
	logic manual_en;
	code_t manual_note;
	logic buz_clk;
	logic playing;
	code_t note;

	string cmd_kind[$];
	string cmd_arg[$];
	int cmd_val[$];
	int exp_note[`SONG_LEN];
	int exp_len[`SONG_LEN];
	int n_entries = 0;
	longint limit_ns = 0;
	int n_tests = 0;
	int n_bad = 0;
	int n_errors = 0;

	buzzer_player_top #(
		.cycles_per_usec(cyc_per_us),
		.usec_per_msec(cyc_per_ms / cyc_per_us)
	) dut0 (
		.clk(clk),
		.reset_p(reset_p),
		.play_start(play_start),
		.play_stop(play_stop),
		.manual_en(manual_en),
		.manual_note(manual_note),
		.buz_clk(buz_clk),
		.playing(playing),
		.note(note)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		wait (limit_ns > 0);
		#(limit_ns);
		$display("watchdog expired after %0d ns, the run is stuck", limit_ns);
		$display("Checks failed");
		$finish;
	end

	// Expected pitch is the top octave value halved once per octave below 9
	function automatic int pitch_hz(input int code);
		int oct;
		int top;
		if (code == 0 || code > `NOTE_MAX) begin
			return 0;
		end
		oct = (code - 1) / 12 + 1;
		case ((code - 1) % 12)
			0:       top = 8372;
			1:       top = 8870;
			2:       top = 9397;
			3:       top = 9956;
			4:       top = 10548;
			5:       top = 11175;
			6:       top = 11840;
			7:       top = 12544;
			8:       top = 13290;
			9:       top = 14080;
			10:      top = 14917;
			default: top = 15804;
		endcase
		return top >> (9 - oct);
	endfunction

	task automatic report_mismatch(input string sig, input longint got, input longint exp);
		$display("MISMATCH %s: got 0x%0h expected 0x%0h", sig, got, exp);
		n_errors++;
	endtask

	task automatic log_result(input string name, input int start_err);
		n_tests++;
		if (n_errors == start_err) begin
			$display("%s: ok", name);
		end else begin
			n_bad++;
			$display("%s: %0d errors", name, n_errors - start_err);
		end
	endtask

	task automatic read_stim();
		int fd;
		int rc;
		int a;
		int b;
		string kw;
		string tok;
		string rest;
		fd = $fopen("sim/buzzer_stim.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file sim/buzzer_stim.txt");
			n_errors++;
			return;
		end
		while (!$feof(fd)) begin
			rc = $fscanf(fd, "%s", kw);
			if (rc != 1) begin
				break;
			end
			if (kw.substr(0, 0) == "#") begin
				rc = $fgets(rest, fd);
			end else if (kw == "entry" && n_entries < `SONG_LEN) begin
				rc = $fscanf(fd, "%d %d", a, b);
				exp_note[n_entries] = a;
				exp_len[n_entries] = b;
				n_entries++;
			end else if (kw == "manual") begin
				rc = $fscanf(fd, "%s %d", tok, a);
				cmd_kind.push_back(kw);
				cmd_arg.push_back(tok);
				cmd_val.push_back(a);
			end else if (kw == "stop" || kw == "song") begin
				a = -1;
				if (kw == "stop") begin
					rc = $fscanf(fd, "%d", a);
				end
				cmd_kind.push_back(kw);
				cmd_arg.push_back("");
				cmd_val.push_back(a);
			end else begin
				$display("unknown command %s in the stimulus file", kw);
				n_errors++;
				rc = $fgets(rest, fd);
			end
		end
		$fclose(fd);
		if (n_entries != `SONG_LEN) begin
			$display("stimulus file holds %0d song entries instead of %0d",
				n_entries, `SONG_LEN);
			n_errors++;
		end
	endtask

	task automatic pulse_start();
		@(negedge clk);
		play_start = 1'b1;
		@(negedge clk);
		play_start = 1'b0;
	endtask

	task automatic pulse_stop();
		@(negedge clk);
		play_stop = 1'b1;
		@(negedge clk);
		play_stop = 1'b0;
	endtask

	// cycles comes back as -1 when note never moves away from the old value
	task automatic wait_note_change(input code_t from, input int max_cycles,
			output int cycles, output int low);
		bit changed;
		changed = 1'b0;
		cycles = 0;
		low = 0;
		while (!changed && cycles < max_cycles) begin
			@(negedge clk);
			cycles++;
			if (note !== from) begin
				changed = 1'b1;
			end else if (playing !== 1'b1) begin
				low++;
			end
		end
		if (!changed) begin
			cycles = -1;
		end
	endtask

	task automatic run_manual(input string tok, input int hold_us);
		int code;
		int f;
		int expect_tog;
		int toggles;
		int start_err;
		logic last;
		start_err = n_errors;
		code = (tok == "R") ? ($urandom % `NOTE_MAX + 1) : tok.atoi();
		@(negedge clk);
		manual_en = 1'b1;
		manual_note = code_t'(code);
		@(negedge clk);
		if (note !== code_t'(code)) begin
			report_mismatch("note", note, code);
		end
		if (playing !== 1'b0) begin
			report_mismatch("playing", playing, 0);
		end
		// Phase restart lands on this edge
		@(negedge clk);
		last = buz_clk;
		toggles = 0;
		repeat (hold_us * cyc_per_us) begin
			@(negedge clk);
			if (buz_clk !== last) begin
				toggles++;
			end
			last = buz_clk;
		end
		f = pitch_hz(code);
		expect_tog = int'((longint'(hold_us) * f) / `HALF_WAVE_UNITS);
		if (f == 0 && toggles != 0) begin
			report_mismatch("buz_clk toggles", toggles, 0);
		end
		if (f != 0 && (toggles < expect_tog - 1 || toggles > expect_tog + 1)) begin
			report_mismatch("buz_clk toggles", toggles, expect_tog);
		end
		manual_en = 1'b0;
		manual_note = '0;
		repeat (2) @(negedge clk);
		log_result($sformatf("manual note %0d for %0d us, %0d toggles", code, hold_us, toggles),
			start_err);
	endtask

	task automatic check_stop_restart();
		int cycles;
		int low;
		int first;
		repeat (3) @(negedge clk);
		pulse_stop();
		if (note !== '0) begin
			report_mismatch("note", note, 0);
		end
		if (playing !== 1'b0) begin
			report_mismatch("playing", playing, 0);
		end
		first = 0;
		while (first < n_entries - 1 && exp_len[first] == 0) begin
			first++;
		end
		pulse_start();
		wait_note_change('0, 2 * cyc_per_ms, cycles, low);
		if (cycles < 0) begin
			$display("song did not restart after play_start");
			n_errors++;
		end else if (note !== code_t'(exp_note[first])) begin
			report_mismatch("note", note, exp_note[first]);
		end
		pulse_stop();
		if (note !== '0 || playing !== 1'b0) begin
			$display("player did not return to idle after the second play_stop");
			n_errors++;
		end
	endtask

	task automatic run_song(input int stop_step);
		code_t cur;
		int i;
		int prev_len;
		int cycles;
		int low;
		int start_err;
		bit aborted;
		start_err = n_errors;
		aborted = 1'b0;
		cur = '0;
		prev_len = 0;
		pulse_start();
		for (i = 0; i < n_entries && !aborted; i++) begin
			if (exp_len[i] != 0) begin
				wait_note_change(cur, (prev_len + 2) * cyc_per_ms, cycles, low);
				if (cycles < 0) begin
					$display("no note change seen before song step %0d", i);
					n_errors++;
					aborted = 1'b1;
				end else begin
					if (low != 0) begin
						$display("playing went low before song step %0d", i);
						n_errors++;
					end
					if (prev_len != 0 && (cycles < (prev_len - 1) * cyc_per_ms ||
							cycles > (prev_len + 1) * cyc_per_ms)) begin
						report_mismatch("note hold cycles", cycles, prev_len * cyc_per_ms);
					end
					if (note !== code_t'(exp_note[i])) begin
						report_mismatch("note", note, exp_note[i]);
					end
					cur = note;
					prev_len = exp_len[i];
					if (i == stop_step) begin
						check_stop_restart();
						aborted = 1'b1;
					end
				end
			end
		end
		if (!aborted) begin
			wait_note_change(cur, (prev_len + 2) * cyc_per_ms, cycles, low);
			if (cycles < 0) begin
				$display("last song note never ended");
				n_errors++;
			end else begin
				if (cycles < (prev_len - 1) * cyc_per_ms ||
						cycles > (prev_len + 1) * cyc_per_ms) begin
					report_mismatch("note hold cycles", cycles, prev_len * cyc_per_ms);
				end
				if (note !== '0) begin
					report_mismatch("note", note, 0);
				end
				if (playing !== 1'b0) begin
					report_mismatch("playing", playing, 0);
				end
			end
		end
		log_result((stop_step < 0) ? "song playback" :
			$sformatf("stop at step %0d and restart", stop_step), start_err);
	endtask

	initial begin
		int c;
		int start_err;
		longint song_ms;
		reset_p = 1'b1;
		play_start = 1'b0;
		play_stop = 1'b0;
		manual_en = 1'b0;
		manual_note = '0;
		void'($urandom(28861));
		read_stim();

		// Watchdog budget is twice the hold times and song length plus a margin
		song_ms = 0;
		for (c = 0; c < n_entries; c++) begin
			song_ms += exp_len[c];
		end
		limit_ns = 20000;
		for (c = 0; c < cmd_kind.size(); c++) begin
			if (cmd_kind[c] == "manual") begin
				limit_ns += 2 * (longint'(cmd_val[c]) * cyc_per_us + 20) * cycle_ns;
			end else begin
				limit_ns += 2 * (song_ms * cyc_per_ms + 200) * cycle_ns;
			end
		end

		repeat (2) @(posedge clk);
		@(negedge clk);
		reset_p = 1'b0;
		start_err = n_errors;
		if (buz_clk !== 1'b0 || playing !== 1'b0 || note !== '0) begin
			$display("outputs are not all zero after reset");
			n_errors++;
		end
		log_result("reset values", start_err);

		for (c = 0; c < cmd_kind.size(); c++) begin
			if (cmd_kind[c] == "manual") begin
				run_manual(cmd_arg[c], cmd_val[c]);
			end else if (cmd_kind[c] == "song") begin
				run_song(-1);
			end else begin
				run_song(cmd_val[c]);
			end
		end

		$display("Summary: %0d tests, %0d with errors, %0d errors in total",
			n_tests, n_bad, n_errors);
		if (n_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/buzzer_stim.txt ====
# Columns: command word, then its arguments, all numbers in decimal
#   manual <note code, or R for random> <hold time in us>
#   entry <expected note code> <length in ms>, one line per song step in order
#   song plays the whole song, stop <step> pulses play_stop while that step plays
manual 1 50000
manual 49 5000
manual 108 1000
manual R 2000
manual R 2000
manual R 2000
manual 0 1000
manual 120 1000
entry 39 62
entry 0 62
entry 39 62
entry 0 62
entry 51 125
entry 0 125
entry 46 187
entry 0 187
entry 45 125
entry 0 125
entry 44 125
entry 0 125
entry 42 125
entry 0 125
entry 39 62
entry 0 62
entry 42 62
entry 0 62
entry 44 62
entry 0 62
entry 37 62
entry 0 62
entry 36 0
entry 37 62
song
stop 6

// ==== flist.f ====
+incdir+verilog
verilog/music_pkg.sv
verilog/player_pkg.sv
verilog/time_base.sv
verilog/pitch_table.sv
verilog/tone_gen.sv
verilog/song_rom.sv
verilog/melody_sequencer.sv
verilog/buzzer_player_top.sv
sim/tb_buzzer_player.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the buzzer player testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f flist.f \
	--top-module tb_buzzer_player -Mdir obj_dir -o sim_buzzer

./obj_dir/sim_buzzer > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log; then
	exit 1
fi
if ! grep -q "All checks passed" sim.log; then
	echo "simulation ended without a result line"
	exit 1
fi
exit 0
